//--- Makefile
# Verilator build and run of the packet queue testbench

VERILATOR ?= verilator
TOP       ?= pkt_queue_tb
FILELIST  ?= pkt_queue.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= STATUS: PASS

.PHONY: sim clean

# the run passes only when the log holds the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- hdl/meta_rx.sv
`timescale 1ns/1ns

module meta_rx (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    in_req,
    output logic                    in_ack,
    input  pkt_queue_pkg::pkt_meta_t in_meta,
    output pkt_queue_pkg::pkt_meta_t meta,
    output logic                    valid,
    input  logic                    ready
);
    import pkt_queue_pkg::*;

    rx_state_t state;
    logic      fire;

    assign fire = valid && ready;

    // ack is high only while we wait for the sender to drop its request
    assign in_ack = (state == rx_wait_req_low);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= rx_idle;
            valid <= 1'b0;
        end else begin
            case (state)
                rx_idle: begin
                    // idle means ack is low and the buffer is empty, so there is room
                    if (in_req) begin
                        valid <= 1'b1;
                        state <= rx_wait_req_low;
                    end
                end
                rx_wait_req_low: begin
                    // the stream may take the item before the sender lets go of req
                    if (fire) begin
                        valid <= 1'b0;
                    end
                    if (!in_req) begin
                        state <= (valid && !fire) ? rx_full : rx_idle;
                    end
                end
                rx_full: begin
                    // ack is already low here, hold the item until it is taken
                    if (fire) begin
                        valid <= 1'b0;
                        state <= rx_idle;
                    end
                end
                default: state <= rx_idle;
            endcase
        end
    end

    // capture on the same edge that raises ack, data is stable while req is high
    always_ff @(posedge clk) begin
        if (state == rx_idle && in_req) begin
            meta <= in_meta;
        end
    end

endmodule

//--- hdl/meta_tx.sv
`timescale 1ns/1ns

module meta_tx (
    input  logic                     clk,
    input  logic                     rst,
    input  pkt_queue_pkg::pkt_meta_t meta,
    input  logic                     valid,
    output logic                     ready,
    output logic                     out_req,
    input  logic                     out_ack,
    output pkt_queue_pkg::pkt_meta_t out_meta
);
    import pkt_queue_pkg::*;

    tx_state_t state;
    logic      fire;

    // one item at a time, a new one is taken only after the last cycle has closed
    assign ready   = (state == tx_idle);
    assign out_req = (state == tx_req);
    assign fire    = valid && ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= tx_idle;
        end else begin
            case (state)
                tx_idle: begin
                    if (fire) begin
                        state <= tx_req;
                    end
                end
                tx_req: begin
                    // drop req once the receiver has taken the data
                    if (out_ack) begin
                        state <= tx_wait_ack_low;
                    end
                end
                tx_wait_ack_low: begin
                    // req may only rise again after ack has gone low
                    if (!out_ack) begin
                        state <= tx_idle;
                    end
                end
                default: state <= tx_idle;
            endcase
        end
    end

    // the register stays put until the next transfer, so data is stable under req
    always_ff @(posedge clk) begin
        if (fire) begin
            out_meta <= meta;
        end
    end

endmodule

//--- hdl/pkt_queue_macros.svh
`ifndef PKT_QUEUE_MACROS_SVH
`define PKT_QUEUE_MACROS_SVH

// global queue id as it arrives from the flow classifier
`define PKT_QUEUE_ID_WIDTH 8

// packet size counted in 64-byte blocks
`define PKT_QUEUE_SIZE_WIDTH 12

// ring pointers and the ring size share this width
`define PKT_QUEUE_PTR_WIDTH 26

`define PKT_QUEUE_FLOW_WIDTH 16

// number of local queues, the local index is taken from the top id bits so keep it a power of two
`define PKT_QUEUE_NB_QUEUES 4

`endif

//--- hdl/pkt_queue_manager.sv
`timescale 1ns/1ns
`include "pkt_queue_macros.svh"

module pkt_queue_manager #(
    parameter int NB_QUEUES = `PKT_QUEUE_NB_QUEUES
) (
    input  logic                            clk,
    input  logic                            rst,
    input  pkt_queue_pkg::pkt_meta_t        in_meta,
    input  logic                            in_meta_valid,
    output logic                            in_meta_ready,
    output pkt_queue_pkg::pkt_meta_t        out_meta,
    output logic                            out_meta_valid,
    input  logic                            out_meta_ready,
    input  pkt_queue_pkg::head_update_t     head_update,
    input  logic [`PKT_QUEUE_PTR_WIDTH-1:0] rb_size
);
    import pkt_queue_pkg::*;

    localparam int QID_WIDTH = $clog2(NB_QUEUES);

    logic [QID_WIDTH-1:0] local_queue_id;
    logic [QID_WIDTH-1:0] out_queue_id;
    queue_state_t         out_q_state;
    pkt_meta_t            out_meta_extra;

    // one bit per queue, set once the host has been told about it
    logic [NB_QUEUES-1:0] pkt_q_status;

    // the local queue comes from the top id bits, the low bits are free for the caller
    assign local_queue_id = in_meta.pkt_queue_id[`PKT_QUEUE_ID_WIDTH-1 -: QID_WIDTH];

    queue_manager #(
        .NB_QUEUES(NB_QUEUES)
    ) u_queue_manager (
        .clk           (clk),
        .rst           (rst),
        .in_queue_id   (local_queue_id),
        .in_size       (in_meta.size),
        .in_meta_extra (in_meta),
        .in_meta_valid (in_meta_valid),
        .in_meta_ready (in_meta_ready),
        .out_q_state   (out_q_state),
        .out_meta_extra(out_meta_extra),
        .out_meta_valid(out_meta_valid),
        .out_meta_ready(out_meta_ready),
        .out_queue_id  (out_queue_id),
        .head_wr_valid (head_update.valid),
        .head_wr_idx   (head_update.queue_idx[QID_WIDTH-1:0]),
        .head_wr_value (head_update.head),
        .rb_size       (rb_size)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            pkt_q_status <= '0;
        end else begin
            if (out_meta_valid && out_meta_ready) begin
                pkt_q_status[out_queue_id] <= 1'b1;
            end
            // a new head means the host caught up, ask for a descriptor next time
            // the later assignment wins when both hit the same queue
            if (head_update.valid) begin
                pkt_q_status[head_update.queue_idx[QID_WIDTH-1:0]] <= 1'b0;
            end
        end
    end

    always_comb begin
        out_meta             = out_meta_extra;
        out_meta.pkt_q_state = out_q_state;
        out_meta.needs_dsc   = !pkt_q_status[out_queue_id];
        out_meta.reserved    = '0;
    end

endmodule

//--- hdl/pkt_queue_pkg.sv
`include "pkt_queue_macros.svh"

package pkt_queue_pkg;

    // ring position of one queue as the host sees it
    typedef struct packed {
        logic [`PKT_QUEUE_PTR_WIDTH-1:0] tail;
        logic [`PKT_QUEUE_PTR_WIDTH-1:0] head;
    } queue_state_t;

    // packet metadata, only the first three fields are meaningful on input
    typedef struct packed {
        logic [`PKT_QUEUE_ID_WIDTH-1:0]   pkt_queue_id;
        logic [`PKT_QUEUE_SIZE_WIDTH-1:0] size;
        logic [`PKT_QUEUE_FLOW_WIDTH-1:0] flow_tag;
        queue_state_t                     pkt_q_state;
        logic                             needs_dsc;
        // pads the struct out to the width used on the external port
        logic [17:0]                      reserved;
    } pkt_meta_t;

    // head pointer write seen on the host interface
    typedef struct packed {
        logic                            valid;
        // wide enough for any queue count, only the low bits are used
        logic [7:0]                      queue_idx;
        logic [`PKT_QUEUE_PTR_WIDTH-1:0] head;
    } head_update_t;

    typedef enum logic [1:0] {
        rx_idle,
        rx_full,
        rx_wait_req_low
    } rx_state_t;

    typedef enum logic [1:0] {
        tx_idle,
        tx_req,
        tx_wait_ack_low
    } tx_state_t;

endpackage

//--- hdl/pkt_queue_top.sv
`timescale 1ns/1ns
`include "pkt_queue_macros.svh"

module pkt_queue_top (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            in_req,
    output logic                            in_ack,
    input  pkt_queue_pkg::pkt_meta_t        in_meta,
    output logic                            out_req,
    input  logic                            out_ack,
    output pkt_queue_pkg::pkt_meta_t        out_meta,
    input  pkt_queue_pkg::head_update_t     head_update,
    input  logic [`PKT_QUEUE_PTR_WIDTH-1:0] rb_size
);
    import pkt_queue_pkg::*;

    // stream from the input port into the queue stage
    pkt_meta_t rx_meta;
    logic      rx_valid;
    logic      rx_ready;

    // stream from the queue stage to the output port
    pkt_meta_t qm_meta;
    logic      qm_valid;
    logic      qm_ready;

    meta_rx u_meta_rx (
        .clk    (clk),
        .rst    (rst),
        .in_req (in_req),
        .in_ack (in_ack),
        .in_meta(in_meta),
        .meta   (rx_meta),
        .valid  (rx_valid),
        .ready  (rx_ready)
    );

    pkt_queue_manager #(
        .NB_QUEUES(`PKT_QUEUE_NB_QUEUES)
    ) u_pkt_queue_manager (
        .clk           (clk),
        .rst           (rst),
        .in_meta       (rx_meta),
        .in_meta_valid (rx_valid),
        .in_meta_ready (rx_ready),
        .out_meta      (qm_meta),
        .out_meta_valid(qm_valid),
        .out_meta_ready(qm_ready),
        .head_update   (head_update),
        .rb_size       (rb_size)
    );

    meta_tx u_meta_tx (
        .clk     (clk),
        .rst     (rst),
        .meta    (qm_meta),
        .valid   (qm_valid),
        .ready   (qm_ready),
        .out_req (out_req),
        .out_ack (out_ack),
        .out_meta(out_meta)
    );

endmodule

//--- hdl/queue_manager.sv
`timescale 1ns/1ns
`include "pkt_queue_macros.svh"

module queue_manager #(
    parameter int NB_QUEUES = `PKT_QUEUE_NB_QUEUES
) (
    input  logic                             clk,
    input  logic                             rst,
    input  logic [$clog2(NB_QUEUES)-1:0]     in_queue_id,
    input  logic [`PKT_QUEUE_SIZE_WIDTH-1:0] in_size,
    input  pkt_queue_pkg::pkt_meta_t         in_meta_extra,
    input  logic                             in_meta_valid,
    output logic                             in_meta_ready,
    output pkt_queue_pkg::queue_state_t      out_q_state,
    output pkt_queue_pkg::pkt_meta_t         out_meta_extra,
    output logic                             out_meta_valid,
    input  logic                             out_meta_ready,
    output logic [$clog2(NB_QUEUES)-1:0]     out_queue_id,
    input  logic                             head_wr_valid,
    input  logic [$clog2(NB_QUEUES)-1:0]     head_wr_idx,
    input  logic [`PKT_QUEUE_PTR_WIDTH-1:0]  head_wr_value,
    input  logic [`PKT_QUEUE_PTR_WIDTH-1:0]  rb_size
);
    import pkt_queue_pkg::*;

    localparam int QID_WIDTH  = $clog2(NB_QUEUES);
    localparam int PTR_WIDTH  = `PKT_QUEUE_PTR_WIDTH;
    localparam int SIZE_WIDTH = `PKT_QUEUE_SIZE_WIDTH;

    // per-queue ring state, small enough to live in flops
    logic [PTR_WIDTH-1:0] tails [NB_QUEUES];
    logic [PTR_WIDTH-1:0] heads [NB_QUEUES];

    // stage A holds the accepted item until stage B has room
    logic                  a_valid;
    pkt_meta_t             a_meta;
    logic [QID_WIDTH-1:0]  a_qid;
    logic [SIZE_WIDTH-1:0] a_size;

    // stage B holds the item with its assigned ring position
    logic                  b_valid;
    pkt_meta_t             b_meta;
    logic [QID_WIDTH-1:0]  b_qid;
    logic [PTR_WIDTH-1:0]  b_tail;

    logic                  in_fire;
    logic                  out_fire;
    logic                  a_move;
    logic [PTR_WIDTH-1:0]  a_tail;
    logic [PTR_WIDTH:0]    tail_sum;
    logic [PTR_WIDTH:0]    tail_wrapped;
    logic [PTR_WIDTH-1:0]  tail_next;

    assign out_fire = out_meta_valid && out_meta_ready;

    // stage A advances when B is empty or is being drained this cycle
    assign a_move        = a_valid && (!b_valid || out_meta_ready);
    assign in_meta_ready = !a_valid || a_move;
    assign in_fire       = in_meta_valid && in_meta_ready;

    // the tail is read when the item leaves A, after any update from the item ahead of it
    assign a_tail = tails[a_qid];

    always_comb begin
        // one extra bit keeps the carry of tail plus size
        tail_sum     = {1'b0, a_tail} + {{(PTR_WIDTH + 1 - SIZE_WIDTH){1'b0}}, a_size};
        tail_wrapped = (tail_sum >= {1'b0, rb_size}) ? tail_sum - {1'b0, rb_size} : tail_sum;
        tail_next    = tail_wrapped[PTR_WIDTH-1:0];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            a_valid <= 1'b0;
            b_valid <= 1'b0;
            for (int i = 0; i < NB_QUEUES; i++) begin
                tails[i] <= '0;
                heads[i] <= '0;
            end
        end else begin
            if (in_fire) begin
                a_valid <= 1'b1;
            end else if (a_move) begin
                a_valid <= 1'b0;
            end

            if (a_move) begin
                b_valid <= 1'b1;
            end else if (out_fire) begin
                b_valid <= 1'b0;
            end

            // the packet takes the old tail, the ring moves on past it
            if (a_move) begin
                tails[a_qid] <= tail_next;
            end

            if (head_wr_valid) begin
                heads[head_wr_idx] <= head_wr_value;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_fire) begin
            a_meta <= in_meta_extra;
            a_qid  <= in_queue_id;
            a_size <= in_size;
        end
        if (a_move) begin
            b_meta <= a_meta;
            b_qid  <= a_qid;
            b_tail <= a_tail;
        end
    end

    assign out_meta_valid    = b_valid;
    assign out_meta_extra    = b_meta;
    assign out_queue_id      = b_qid;
    assign out_q_state.tail  = b_tail;
    // head is read live so a host write reaches the item already waiting in B
    assign out_q_state.head  = heads[b_qid];

endmodule

//--- pkt_queue.f
+incdir+hdl
hdl/pkt_queue_pkg.sv
hdl/meta_rx.sv
hdl/queue_manager.sv
hdl/pkt_queue_manager.sv
hdl/meta_tx.sv
hdl/pkt_queue_top.sv
verification/pkt_queue_checker.sv
verification/pkt_queue_tb.sv

//--- verification/pkt_queue_checker.sv
`timescale 1ns/1ns

module pkt_queue_checker (
    input logic                     clk,
    input logic                     rst,
    input logic                     in_req,
    input logic                     in_ack,
    input pkt_queue_pkg::pkt_meta_t in_meta,
    input logic                     out_req,
    input logic                     out_ack,
    input pkt_queue_pkg::pkt_meta_t out_meta
);

    // the producer reacts to ack within the cycle, so its edges line up with the current ack
    in_req_rise: assert property (@(posedge clk) disable iff (rst) $rose(in_req) |-> !in_ack)
        else $error("in_req rose while in_ack was high");
    in_req_fall: assert property (@(posedge clk) disable iff (rst) $fell(in_req) |-> in_ack)
        else $error("in_req fell before in_ack rose");

    // the receiver registers its answer, so ack follows the req seen one edge earlier
    in_ack_rise: assert property (@(posedge clk) disable iff (rst)
        $rose(in_ack) |-> $past(in_req))
        else $error("in_ack rose without a request");
    in_ack_fall: assert property (@(posedge clk) disable iff (rst)
        $fell(in_ack) |-> !$past(in_req))
        else $error("in_ack fell while in_req was still high");

    in_data_stable: assert property (@(posedge clk) disable iff (rst)
        in_req && $past(in_req) |-> $stable(in_meta))
        else $error("in_meta changed under in_req");

    // output side, the DUT is the sender here
    out_req_rise: assert property (@(posedge clk) disable iff (rst)
        $rose(out_req) |-> !$past(out_ack))
        else $error("out_req rose before out_ack was low");
    out_req_fall: assert property (@(posedge clk) disable iff (rst)
        $fell(out_req) |-> $past(out_ack))
        else $error("out_req fell without an ack");
    out_ack_rise: assert property (@(posedge clk) disable iff (rst) $rose(out_ack) |-> out_req)
        else $error("out_ack rose without a request");
    out_ack_fall: assert property (@(posedge clk) disable iff (rst) $fell(out_ack) |-> !out_req)
        else $error("out_ack fell while out_req was high");

    out_data_stable: assert property (@(posedge clk) disable iff (rst)
        out_req && $past(out_req) |-> $stable(out_meta))
        else $error("out_meta changed under out_req");

    // both handshake outputs come out of reset low
    reset_values: assert property (@(posedge clk) rst |=> !in_ack && !out_req)
        else $error("in_ack or out_req high after reset");

endmodule

bind pkt_queue_top pkt_queue_checker u_pkt_queue_checker (
    .clk     (clk),
    .rst     (rst),
    .in_req  (in_req),
    .in_ack  (in_ack),
    .in_meta (in_meta),
    .out_req (out_req),
    .out_ack (out_ack),
    .out_meta(out_meta)
);

//--- verification/pkt_queue_tb.sv
`timescale 1ns/1ns
`include "pkt_queue_macros.svh"

module pkt_queue_tb;
    import pkt_queue_pkg::*;

    localparam int NBQ        = `PKT_QUEUE_NB_QUEUES;
    localparam int QBITS      = $clog2(NBQ);
    localparam int WAIT_LIMIT = 500;
    // small ring so that the tails wrap after a handful of packets
    localparam logic [`PKT_QUEUE_PTR_WIDTH-1:0] RING_SIZE = 26'd37;

    logic         clk = 1'b0;
    logic         rst;
    logic         in_req;
    logic         in_ack;
    pkt_meta_t    in_meta;
    logic         out_req;
    logic         out_ack;
    pkt_meta_t    out_meta;
    head_update_t head_update;
    logic [`PKT_QUEUE_PTR_WIDTH-1:0] rb_size;

    // reference model of the ring tables and the descriptor status bits
    logic [`PKT_QUEUE_PTR_WIDTH-1:0] model_tail [NBQ];
    logic [`PKT_QUEUE_PTR_WIDTH-1:0] model_head [NBQ];
    logic [NBQ-1:0]                  model_status;
    pkt_meta_t                       expected_q [$];

    int          mismatches;
    int          timeouts;
    int          other_errors;
    logic [31:0] lcg_state;
    logic        qm_handshake;

    // high in the cycle that ends in a transfer from the queue manager to the output side
    assign qm_handshake = u_pkt_queue_top.u_pkt_queue_manager.out_meta_valid &&
                          u_pkt_queue_top.u_pkt_queue_manager.out_meta_ready;

    pkt_queue_top u_pkt_queue_top (
        .clk        (clk),
        .rst        (rst),
        .in_req     (in_req),
        .in_ack     (in_ack),
        .in_meta    (in_meta),
        .out_req    (out_req),
        .out_ack    (out_ack),
        .out_meta   (out_meta),
        .head_update(head_update),
        .rb_size    (rb_size)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    task automatic report_timeout(input string what);
        timeouts++;
        $display("timeout at %0t ns while waiting for %s", $time, what);
    endtask

    task automatic check_field(input string name, input logic [63:0] got,
                               input logic [63:0] want);
        assert (got === want) else begin
            mismatches++;
            $display("mismatch at %0t ns: %s got %0h expected %0h", $time, name, got, want);
        end
    endtask

    task automatic compare_packet(input pkt_meta_t got);
        pkt_meta_t want;
        if (expected_q.size() == 0) begin
            other_errors++;
            $display("packet came out at %0t ns with none expected", $time);
            return;
        end
        want = expected_q.pop_front();
        check_field("pkt_queue_id", 64'(got.pkt_queue_id), 64'(want.pkt_queue_id));
        check_field("size", 64'(got.size), 64'(want.size));
        check_field("flow_tag", 64'(got.flow_tag), 64'(want.flow_tag));
        check_field("tail", 64'(got.pkt_q_state.tail), 64'(want.pkt_q_state.tail));
        check_field("head", 64'(got.pkt_q_state.head), 64'(want.pkt_q_state.head));
        check_field("needs_dsc", 64'(got.needs_dsc), 64'(want.needs_dsc));
        check_field("reserved", 64'(got.reserved), 64'(want.reserved));
    endtask

    // picks a random packet, predicts its output and runs the four-phase sender
    task automatic send_packet(input int queue);
        logic [31:0]      r;
        pkt_meta_t        m;
        pkt_meta_t        e;
        logic [QBITS-1:0] q;
        int               t;
        int               n;
        r = lcg_next();
        m = '0;
        m.pkt_queue_id = r[31:24];
        // a fixed queue pins only the top id bits and leaves the low bits random
        if (queue >= 0) begin
            m.pkt_queue_id[`PKT_QUEUE_ID_WIDTH-1 -: QBITS] = queue[QBITS-1:0];
        end
        m.size = (r[23:12] % 12'd30) + 12'd1;
        r = lcg_next();
        m.flow_tag = r[31:16];
        // the stage fills in the remaining fields, so junk offered there must not come out
        r = lcg_next();
        m.needs_dsc = r[31];
        m.reserved = r[17:0];
        q = m.pkt_queue_id[`PKT_QUEUE_ID_WIDTH-1 -: QBITS];
        // the packet sits at the old tail and sees the head as it stands now
        e = m;
        e.reserved = '0;
        e.pkt_q_state.tail = model_tail[q];
        e.pkt_q_state.head = model_head[q];
        e.needs_dsc = !model_status[q];
        model_status[q] = 1'b1;
        t = int'(model_tail[q]) + int'(m.size);
        if (t >= int'(rb_size)) begin
            t = t - int'(rb_size);
        end
        model_tail[q] = t[`PKT_QUEUE_PTR_WIDTH-1:0];
        expected_q.push_back(e);
        @(negedge clk);
        in_meta = m;
        in_req = 1'b1;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (in_ack !== 1'b1 && n < WAIT_LIMIT);
        if (in_ack !== 1'b1) begin
            report_timeout("in_ack to rise");
        end
        in_req = 1'b0;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (in_ack !== 1'b0 && n < WAIT_LIMIT);
        if (in_ack !== 1'b0) begin
            report_timeout("in_ack to fall");
        end
    endtask

    // runs the four-phase receiver and acks each packet after a random number of cycles
    task automatic receive_packets(input int count, input int max_delay);
        logic [31:0] r;
        pkt_meta_t   got;
        int          n;
        for (int k = 0; k < count; k++) begin
            n = 0;
            do begin
                @(negedge clk);
                n++;
            end while (out_req !== 1'b1 && n < WAIT_LIMIT);
            if (out_req !== 1'b1) begin
                report_timeout("out_req to rise");
                return;
            end
            got = out_meta;
            r = lcg_next();
            repeat (int'(r[15:8]) % (max_delay + 1)) @(negedge clk);
            out_ack = 1'b1;
            n = 0;
            do begin
                @(negedge clk);
                n++;
            end while (out_req !== 1'b0 && n < WAIT_LIMIT);
            if (out_req !== 1'b0) begin
                report_timeout("out_req to fall");
            end
            out_ack = 1'b0;
            compare_packet(got);
        end
    endtask

    // a negative queue sends each packet to a random queue
    task automatic run_traffic(input int count, input int queue, input int max_delay);
        fork
            begin
                for (int k = 0; k < count; k++) begin
                    send_packet(queue);
                end
            end
            receive_packets(count, max_delay);
        join
    endtask

    // called on a falling edge so that the strobe is seen at the next rising edge
    task automatic write_head(input int queue, input logic [`PKT_QUEUE_PTR_WIDTH-1:0] head);
        logic [QBITS-1:0] q;
        q = queue[QBITS-1:0];
        head_update.valid = 1'b1;
        head_update.queue_idx = 8'(q);
        head_update.head = head;
        model_head[q] = head;
        model_status[q] = 1'b0;
        @(negedge clk);
        head_update = '0;
    endtask

    // lines the head write up with the next transfer into the output side
    task automatic write_head_at_handshake(input int queue,
                                           input logic [`PKT_QUEUE_PTR_WIDTH-1:0] head);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!qm_handshake && n < WAIT_LIMIT);
        if (!qm_handshake) begin
            report_timeout("the queue manager output transfer");
        end else begin
            write_head(queue, head);
        end
    endtask

    initial begin
        rst = 1'b1;
        in_req = 1'b0;
        in_meta = '0;
        out_ack = 1'b0;
        head_update = '0;
        rb_size = RING_SIZE;
        lcg_state = 32'd88845;
        mismatches = 0;
        timeouts = 0;
        other_errors = 0;
        model_status = '0;
        for (int i = 0; i < NBQ; i++) begin
            model_tail[i] = '0;
            model_head[i] = '0;
        end
        repeat (10) @(negedge clk);
        rst = 1'b0;
        // with nothing offered neither handshake line may move
        repeat (20) begin
            @(negedge clk);
            assert (in_ack === 1'b0 && out_req === 1'b0) else begin
                other_errors++;
                $display("handshake line high at %0t ns with no traffic offered", $time);
            end
        end
        // back-to-back packets to one queue run past the end of the small ring
        run_traffic(6, 1, 2);
        @(negedge clk);
        write_head(1, 26'd7);
        run_traffic(3, 1, 2);
        // neighbours keep their own tails and status bits
        run_traffic(4, 2, 3);
        run_traffic(4, 0, 3);
        // mixed queues with slow acks so that the pipeline backs up
        run_traffic(40, -1, 40);
        // head write on the very edge that the status bit is set
        run_traffic(1, 3, 0);
        fork
            run_traffic(1, 3, 4);
            write_head_at_handshake(3, 26'd11);
        join
        run_traffic(2, 3, 0);
        if (expected_q.size() != 0) begin
            other_errors++;
            $display("%0d expected packets never came out", expected_q.size());
        end
        $display("errors: %0d mismatches, %0d timeouts, %0d other",
                 mismatches, timeouts, other_errors);
        if (mismatches + timeouts + other_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule
